// ==== fftPipeline.f ====
source/fftPkg.sv
source/sampleWindow.sv
source/radix2Butterfly.sv
source/fftStage.sv
source/fftPipeline.sv
tests/fftChecker.sv
tests/fftPipeline_sva.sv
tests/fftPipelineTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build and run the FFT testbench with Verilator
set -e

cd "$(dirname "$0")"

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module fftPipelineTb \
	-f fftPipeline.f \
	-o simFft

./obj_dir/simFft > "$logFile" 2>&1 || true
cat "$logFile"

if grep -q "=== FAIL ===" "$logFile"; then
	exit 1
fi
if ! grep -q "=== PASS ===" "$logFile"; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0

// ==== source/fftPipeline.sv ====
// Top level of the sliding-window FFT, sample window followed by a chain of stages
`default_nettype none
`timescale 1ns/1ns

module fftPipeline #(
	parameter int dataWidth = 24
) (
	input logic advanceSignal,
	input logic reset,
	input fftPkg::sampleT sampleIn,
	input logic sampleStrobe,
	output fftPkg::wordT fftOut [fftPkg::fftPoints],
	output logic outputValid
);

	// Entry s feeds stage s, entry fftLog is the chain output
	fftPkg::wordT chainReal [fftPkg::fftLog+1][fftPkg::fftPoints];
	fftPkg::wordT chainImag [fftPkg::fftLog+1][fftPkg::fftPoints];
	logic [fftPkg::fftLog:0] chainReady;
	// Busy of stage s, top entry has no stage behind it
	logic [fftPkg::fftLog:0] chainBusy;

	sampleWindow #(
		.dataWidth(dataWidth)
	) sampleWindow_i (
		.advanceSignal(advanceSignal),
		.reset(reset),
		.sampleIn(sampleIn),
		.sampleStrobe(sampleStrobe),
		.stageBusy(chainBusy[0]),
		.frameReal(chainReal[0]),
		.frameRequest(chainReady[0])
	);

	// Real input only
	assign chainImag[0] = '{default: '0};

	for (genvar s = 0; s < fftPkg::fftLog; s++) begin : genStage
		fftStage #(
			.dataWidth(dataWidth),
			.stageIndex(s)
		) fftStage_i (
			.advanceSignal(advanceSignal),
			.reset(reset),
			.inReal(chainReal[s]),
			.inImag(chainImag[s]),
			.inReady(chainReady[s]),
			.nextBusy(chainBusy[s+1]),
			.outReal(chainReal[s+1]),
			.outImag(chainImag[s+1]),
			.outReady(chainReady[s+1]),
			.stageBusy(chainBusy[s])
		);
	end

	// Nothing downstream of the last stage
	assign chainBusy[fftPkg::fftLog] = 1'b0;

	// Real bins only, held until the next frame lands
	assign fftOut = chainReal[fftPkg::fftLog];
	assign outputValid = chainReady[fftPkg::fftLog];

endmodule

`default_nettype wire

// ==== source/fftPkg.sv ====
// FFT package with shared widths, twiddle table and butterfly index helpers
`default_nettype none

package fftPkg;

	// Transform size
	localparam int fftPoints = 8;
	localparam int fftLog = 3;
	localparam int bflyPerStage = fftPoints / 2;

	// Fixed-point format of samples, datapath words and twiddles
	localparam int sampleWidth = 12;
	localparam int fracBits = 8;
	localparam int wordWidth = 24;

	typedef logic signed [sampleWidth-1:0] sampleT;
	typedef logic signed [wordWidth-1:0] wordT;
	// Two extra bits so +1.0 (256) fits
	typedef logic signed [fracBits+1:0] coefT;
	typedef logic [fftLog-1:0] pointIndexT;
	typedef logic [fftLog-2:0] bflyCountT;

	// Iterative stage sequencing
	typedef enum logic [1:0] {
		stageIdle,
		stageCompute,
		stageHold
	} stageStateT;

	// W^k = exp(-j*2*pi*k/8) scaled by 2^fracBits
	localparam coefT twiddleReal [bflyPerStage] = '{
		coefT'(256), coefT'(181), coefT'(0), coefT'(-181)
	};
	localparam coefT twiddleImag [bflyPerStage] = '{
		coefT'(0), coefT'(-181), coefT'(-256), coefT'(-181)
	};

	// Reverse the bits of a frame index
	function automatic pointIndexT bitReverse(input pointIndexT index);
		pointIndexT reversed;
		for (int b = 0; b < fftLog; b++) begin
			reversed[b] = index[fftLog-1-b];
		end
		return reversed;
	endfunction

	// Upper input of butterfly j in stage s, half span 2^s
	function automatic pointIndexT bflyIndexA(input int stage, input bflyCountT bfly);
		int half;
		int j;
		half = 1 << stage;
		j = int'(bfly);
		return pointIndexT'((j / half) * 2 * half + (j % half));
	endfunction

	// Lower input sits one half span above
	function automatic pointIndexT bflyIndexB(input int stage, input bflyCountT bfly);
		int half;
		half = 1 << stage;
		return pointIndexT'(int'(bflyIndexA(stage, bfly)) + half);
	endfunction

	// Twiddle exponent for butterfly j in stage s
	function automatic bflyCountT twiddleIndex(input int stage, input bflyCountT bfly);
		int half;
		int j;
		half = 1 << stage;
		j = int'(bfly);
		// Early stages only touch the low twiddles
		return bflyCountT'((j % half) * (fftPoints / (2 * half)));
	endfunction

endpackage

`default_nettype wire

// ==== source/fftStage.sv ====
// One iterative FFT stage with in-place frame buffer and a single shared butterfly
`default_nettype none
`timescale 1ns/1ns

module fftStage #(
	parameter int dataWidth = 24,
	parameter int stageIndex = 0
) (
	input logic advanceSignal,
	input logic reset,
	input fftPkg::wordT inReal [fftPkg::fftPoints],
	input fftPkg::wordT inImag [fftPkg::fftPoints],
	input logic inReady,
	input logic nextBusy,
	output fftPkg::wordT outReal [fftPkg::fftPoints],
	output fftPkg::wordT outImag [fftPkg::fftPoints],
	output logic outReady,
	output logic stageBusy
);

	// Last stage feeds the output port, which never stalls
	localparam bit lastStage = (stageIndex == fftPkg::fftLog - 1);

	fftPkg::stageStateT state;
	fftPkg::bflyCountT bflyCount;

	// Frame being worked on, rewritten in place
	fftPkg::wordT bufReal [fftPkg::fftPoints];
	fftPkg::wordT bufImag [fftPkg::fftPoints];

	// Butterfly operand selection
	fftPkg::pointIndexT idxA;
	fftPkg::pointIndexT idxB;
	fftPkg::bflyCountT twIdx;
	fftPkg::wordT sumReal;
	fftPkg::wordT sumImag;
	fftPkg::wordT diffReal;
	fftPkg::wordT diffImag;

	always_comb begin
		idxA = fftPkg::bflyIndexA(stageIndex, bflyCount);
		idxB = fftPkg::bflyIndexB(stageIndex, bflyCount);
		twIdx = fftPkg::twiddleIndex(stageIndex, bflyCount);
	end

	radix2Butterfly #(
		.dataWidth(dataWidth)
	) butterfly_i (
		.aReal(bufReal[idxA]),
		.aImag(bufImag[idxA]),
		.bReal(bufReal[idxB]),
		.bImag(bufImag[idxB]),
		.wReal(fftPkg::twiddleReal[twIdx]),
		.wImag(fftPkg::twiddleImag[twIdx]),
		.sumReal(sumReal),
		.sumImag(sumImag),
		.diffReal(diffReal),
		.diffImag(diffImag)
	);

	always_ff @(posedge advanceSignal) begin
		if (reset) begin
			state <= fftPkg::stageIdle;
			bflyCount <= '0;
			bufReal <= '{default: '0};
			bufImag <= '{default: '0};
		end else begin
			case (state)
				fftPkg::stageIdle: begin
					// outReady is low whenever the stage is idle
					if (inReady) begin
						bufReal <= inReal;
						bufImag <= inImag;
						bflyCount <= '0;
						state <= fftPkg::stageCompute;
					end
				end
				fftPkg::stageCompute: begin
					// One butterfly per cycle, results written in place
					bufReal[idxA] <= sumReal;
					bufImag[idxA] <= sumImag;
					bufReal[idxB] <= diffReal;
					bufImag[idxB] <= diffImag;
					bflyCount <= bflyCount + 1'b1;
					if (bflyCount == fftPkg::bflyCountT'(fftPkg::bflyPerStage - 1)) begin
						state <= fftPkg::stageHold;
					end
				end
				fftPkg::stageHold: begin
					// Frame stays put until the next stage has started on it
					if (nextBusy || lastStage) begin
						state <= fftPkg::stageIdle;
					end
				end
				default: begin
					state <= fftPkg::stageIdle;
				end
			endcase
		end
	end

	// Handshake levels decoded from the registered state
	assign outReady = (state == fftPkg::stageHold);
	assign stageBusy = (state == fftPkg::stageCompute);

	assign outReal = bufReal;
	assign outImag = bufImag;

endmodule

`default_nettype wire

// ==== source/radix2Butterfly.sv ====
// Radix-2 complex butterfly with fixed-point twiddle multiply
`default_nettype none
`timescale 1ns/1ns

module radix2Butterfly #(
	parameter int dataWidth = 24
) (
	input fftPkg::wordT aReal,
	input fftPkg::wordT aImag,
	input fftPkg::wordT bReal,
	input fftPkg::wordT bImag,
	input fftPkg::coefT wReal,
	input fftPkg::coefT wImag,
	output fftPkg::wordT sumReal,
	output fftPkg::wordT sumImag,
	output fftPkg::wordT diffReal,
	output fftPkg::wordT diffImag
);

	// Full width of one complex product term plus the add
	localparam int prodWidth = dataWidth + $bits(fftPkg::coefT) + 1;

	logic signed [dataWidth-1:0] bScaledReal;
	logic signed [dataWidth-1:0] bScaledImag;
	logic signed [prodWidth-1:0] fullReal;
	logic signed [prodWidth-1:0] fullImag;
	logic signed [dataWidth-1:0] prodReal;
	logic signed [dataWidth-1:0] prodImag;

	// Drop the fraction of b ahead of the twiddle multiply
	assign bScaledReal = bReal >>> fftPkg::fracBits;
	assign bScaledImag = bImag >>> fftPkg::fracBits;

	// w * b'
	assign fullReal = wReal * bScaledReal - wImag * bScaledImag;
	assign fullImag = wReal * bScaledImag + wImag * bScaledReal;

	// Truncate back to the datapath word
	assign prodReal = fullReal[dataWidth-1:0];
	assign prodImag = fullImag[dataWidth-1:0];

	// Sum goes back to index a, difference to index b
	assign sumReal = aReal + prodReal;
	assign sumImag = aImag + prodImag;
	assign diffReal = aReal - prodReal;
	assign diffImag = aImag - prodImag;

endmodule

`default_nettype wire

// ==== source/sampleWindow.sv ====
// Sample window keeping the last eight samples and presenting a bit-reversed scaled frame
`default_nettype none
`timescale 1ns/1ns

module sampleWindow #(
	parameter int dataWidth = 24
) (
	input logic advanceSignal,
	input logic reset,
	input fftPkg::sampleT sampleIn,
	input logic sampleStrobe,
	input logic stageBusy,
	output fftPkg::wordT frameReal [fftPkg::fftPoints],
	output logic frameRequest
);

	// Position p holds the sample taken p strobes ago
	fftPkg::sampleT window [fftPkg::fftPoints];

	always_ff @(posedge advanceSignal) begin
		if (reset) begin
			window <= '{default: '0};
		end else if (sampleStrobe) begin
			// Newest sample enters at position 0
			window[0] <= sampleIn;
			for (int p = 1; p < fftPkg::fftPoints; p++) begin
				window[p] <= window[p-1];
			end
		end
	end

	// Frame request to stage 0
	always_ff @(posedge advanceSignal) begin
		if (reset) begin
			frameRequest <= 1'b0;
		end else if (sampleStrobe) begin
			// New strobe always wins over a pending clear
			frameRequest <= 1'b1;
		end else if (stageBusy) begin
			// Stage 0 has taken the frame
			frameRequest <= 1'b0;
		end
	end

	// Frame element i is x[bitReverse(i)]
	for (genvar i = 0; i < fftPkg::fftPoints; i++) begin : genFrame
		// x[n] lives at window position fftPoints-1-n
		localparam fftPkg::pointIndexT srcIndex =
			fftPkg::pointIndexT'(fftPkg::fftPoints - 1)
			- fftPkg::bitReverse(fftPkg::pointIndexT'(i));

		logic signed [dataWidth-1:0] extended;

		// Sign extend first, then move into fixed point
		assign extended = dataWidth'(window[srcIndex]);
		assign frameReal[i] = extended <<< fftPkg::fracBits;
	end

endmodule

`default_nettype wire

// ==== tests/fftCases.txt ====
# columns 1-8: samples, oldest first; columns 9-16: expected real bins 0..7
# bins carry 8 fraction bits, twiddles use 181 for 0.7071
3 3 3 3 3 3 3 3 6144 0 0 0 0 0 0 0
-2 -2 -2 -2 -2 -2 -2 -2 -4096 0 0 0 0 0 0 0
100 0 0 0 0 0 0 0 25600 25600 25600 25600 25600 25600 25600 25600
0 4 0 0 0 0 0 0 1024 724 0 -724 -1024 -724 0 724
1 -1 1 -1 1 -1 1 -1 0 0 0 0 2048 0 0 0
2 0 -2 0 2 0 -2 0 0 0 2048 0 0 0 2048 0

// ==== tests/fftChecker.sv ====
// FFT output checker with its own sliding window and fixed-point DIT reference model
`default_nettype none
`timescale 1ns/1ns

module fftChecker (
	input logic advanceSignal,
	input logic reset,
	input fftPkg::sampleT sampleIn,
	input logic sampleStrobe,
	input fftPkg::wordT fftOut [fftPkg::fftPoints],
	input logic outputValid,
	input logic caseArm,
	input fftPkg::wordT caseBins [fftPkg::fftPoints],
	output int errorCount,
	output int strobeCount,
	output int outputCount,
	output int caseHits,
	output int pendingCount
);

	localparam int wordWidth = $bits(fftPkg::wordT);
	localparam int points = fftPkg::fftPoints;

	typedef logic [points*wordWidth-1:0] frameT;

	// Newest sample at position 0
	fftPkg::sampleT modelWindow [points] = '{default: '0};
	frameT expectQueue [$];
	bit quietSinceReset = 1'b1;
	int errors = 0;
	int strobes = 0;
	int outputs = 0;
	int hits = 0;

	assign errorCount = errors;
	assign strobeCount = strobes;
	assign outputCount = outputs;
	assign caseHits = hits;
	assign pendingCount = expectQueue.size();

	function automatic int reverseBits(input int index);
		int result;
		result = 0;
		for (int b = 0; b < fftPkg::fftLog; b++) begin
			if (index & (1 << b)) result |= 1 << (fftPkg::fftLog - 1 - b);
		end
		return result;
	endfunction

	// Radix-2 DIT over x[n] = window[7-n], b scaled down before the twiddle
	function automatic frameT modelFrame(input fftPkg::sampleT win [points]);
		fftPkg::wordT re [points];
		fftPkg::wordT im [points];
		fftPkg::wordT br;
		fftPkg::wordT bi;
		fftPkg::wordT pr;
		fftPkg::wordT pi;
		fftPkg::wordT ar;
		fftPkg::wordT ai;
		frameT packedFrame;
		int half;
		int a;
		int b;
		int k;
		for (int i = 0; i < points; i++) begin
			re[i] = fftPkg::wordT'(longint'(win[points - 1 - reverseBits(i)])
				* (longint'(1) << fftPkg::fracBits));
			im[i] = '0;
		end
		for (int s = 0; s < fftPkg::fftLog; s++) begin
			half = 1 << s;
			for (int j = 0; j < points / 2; j++) begin
				a = (j / half) * 2 * half + (j % half);
				b = a + half;
				k = (j % half) * (points / (2 * half));
				br = re[b] >>> fftPkg::fracBits;
				bi = im[b] >>> fftPkg::fracBits;
				pr = fftPkg::wordT'(longint'(fftPkg::twiddleReal[k]) * br
					- longint'(fftPkg::twiddleImag[k]) * bi);
				pi = fftPkg::wordT'(longint'(fftPkg::twiddleReal[k]) * bi
					+ longint'(fftPkg::twiddleImag[k]) * br);
				ar = re[a];
				ai = im[a];
				re[a] = ar + pr;
				im[a] = ai + pi;
				re[b] = ar - pr;
				im[b] = ai - pi;
			end
		end
		for (int i = 0; i < points; i++) begin
			packedFrame[i*wordWidth +: wordWidth] = re[i];
		end
		return packedFrame;
	endfunction

	always @(posedge advanceSignal) begin
		frameT expected;
		fftPkg::wordT want;
		if (reset) begin
			// Model cleared with the DUT
			modelWindow = '{default: '0};
			expectQueue.delete();
			quietSinceReset = 1'b1;
		end else begin
			if (quietSinceReset) begin
				if (outputValid) begin
					$display("outputValid went high at %0t ns before any strobe after reset", $time);
					errors++;
				end
				for (int i = 0; i < points; i++) begin
					if (fftOut[i] != '0) begin
						$display("[ERROR] %0t ns: bin %0d is %0d after reset, expected 0",
							$time, i, fftOut[i]);
						errors++;
					end
				end
			end
			if (outputValid) begin
				outputs++;
				if (expectQueue.size() == 0) begin
					$display("outputValid at %0t ns with no frame pending", $time);
					errors++;
				end else begin
					expected = expectQueue.pop_front();
					for (int i = 0; i < points; i++) begin
						want = expected[i*wordWidth +: wordWidth];
						if (fftOut[i] != want) begin
							$display("[ERROR] %0t ns: bin %0d expected %0d from model, got %0d",
								$time, i, want, fftOut[i]);
							errors++;
						end
					end
				end
				// File values for a full case window
				if (caseArm) begin
					hits++;
					for (int i = 0; i < points; i++) begin
						if (fftOut[i] != caseBins[i]) begin
							$display("[ERROR] %0t ns: bin %0d expected %0d from case file, got %0d",
								$time, i, caseBins[i], fftOut[i]);
							errors++;
						end
					end
				end
			end
			if (sampleStrobe) begin
				for (int p = points - 1; p > 0; p--) begin
					modelWindow[p] = modelWindow[p-1];
				end
				modelWindow[0] = sampleIn;
				expectQueue.push_back(modelFrame(modelWindow));
				strobes++;
				quietSinceReset = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tests/fftPipelineTb.sv ====
// Testbench top for the sliding-window FFT, drives case and random strobes and reports the result
`default_nettype none
`timescale 1ns/1ns

module fftPipelineTb;

	localparam int maxCases = 16;
	localparam int clockPeriod = 100;
	localparam int strobeSpacing = 20;
	localparam int rowLength = 2 * fftPkg::fftPoints;

	logic advanceSignal;
	logic reset;
	fftPkg::sampleT sampleIn;
	logic sampleStrobe;
	fftPkg::wordT fftOut [fftPkg::fftPoints];
	logic outputValid;

	// Expected bins of the case in flight
	logic caseArm;
	fftPkg::wordT caseBins [fftPkg::fftPoints];

	int errorCount;
	int strobeCount;
	int outputCount;
	int caseHits;
	int pendingCount;
	int otherErrors;

	// Samples oldest first, then expected real bins
	int caseData [maxCases][rowLength];
	int numCases;
	bit casesLoaded;

	initial begin
		advanceSignal = 1'b0;
		forever #(clockPeriod / 2) advanceSignal = ~advanceSignal;
	end

	fftPipeline #(
		.dataWidth(24)
	) fftPipeline_i (
		.advanceSignal(advanceSignal),
		.reset(reset),
		.sampleIn(sampleIn),
		.sampleStrobe(sampleStrobe),
		.fftOut(fftOut),
		.outputValid(outputValid)
	);

	fftChecker checker_i (
		.advanceSignal(advanceSignal),
		.reset(reset),
		.sampleIn(sampleIn),
		.sampleStrobe(sampleStrobe),
		.fftOut(fftOut),
		.outputValid(outputValid),
		.caseArm(caseArm),
		.caseBins(caseBins),
		.errorCount(errorCount),
		.strobeCount(strobeCount),
		.outputCount(outputCount),
		.caseHits(caseHits),
		.pendingCount(pendingCount)
	);

	// One line per case, lines starting with # are skipped
	task automatic readCases();
		int fd;
		int got;
		string line;
		int v [rowLength];
		numCases = 0;
		fd = $fopen("tests/fftCases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the case file tests/fftCases.txt");
			otherErrors++;
			return;
		end
		while (!$feof(fd) && numCases < maxCases) begin
			got = $fgets(line, fd);
			if (got == 0 || line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			got = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
				v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
				v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]);
			if (got != rowLength) begin
				$display("Case file line has %0d values instead of %0d", got, rowLength);
				otherErrors++;
				continue;
			end
			for (int k = 0; k < rowLength; k++) begin
				caseData[numCases][k] = v[k];
			end
			numCases++;
		end
		$fclose(fd);
	endtask

	// Single strobe, then idle up to the next strobe slot
	task automatic pulseStrobe(input fftPkg::sampleT value);
		@(negedge advanceSignal);
		sampleIn = value;
		sampleStrobe = 1'b1;
		@(negedge advanceSignal);
		sampleStrobe = 1'b0;
		repeat (strobeSpacing - 2) @(negedge advanceSignal);
	endtask

	initial begin
		int seedDummy;
		reset = 1'b1;
		sampleIn = '0;
		sampleStrobe = 1'b0;
		caseArm = 1'b0;
		caseBins = '{default: '0};
		otherErrors = 0;
		casesLoaded = 1'b0;
		seedDummy = $urandom(32'h05ad1b48);

		readCases();
		casesLoaded = 1'b1;

		repeat (4) @(negedge advanceSignal);
		reset = 1'b0;
		// Quiet time, outputs must stay zero
		repeat (10) @(negedge advanceSignal);

		for (int c = 0; c < numCases; c++) begin
			for (int n = 0; n < fftPkg::fftPoints; n++) begin
				if (n == fftPkg::fftPoints - 1) begin
					// Window is full of this case from here on
					for (int k = 0; k < fftPkg::fftPoints; k++) begin
						caseBins[k] = fftPkg::wordT'(caseData[c][fftPkg::fftPoints + k]);
					end
					caseArm = 1'b1;
				end
				pulseStrobe(fftPkg::sampleT'(caseData[c][n]));
			end
			caseArm = 1'b0;
		end

		// Random samples
		repeat (6) pulseStrobe(fftPkg::sampleT'($urandom));

		// Strobe, then reset in the middle of its frame
		@(negedge advanceSignal);
		sampleIn = fftPkg::sampleT'($urandom);
		sampleStrobe = 1'b1;
		@(negedge advanceSignal);
		sampleStrobe = 1'b0;
		repeat (6) @(negedge advanceSignal);
		reset = 1'b1;
		repeat (4) @(negedge advanceSignal);
		reset = 1'b0;
		repeat (10) @(negedge advanceSignal);

		// Second burst against a cleared window
		repeat (4) pulseStrobe(fftPkg::sampleT'($urandom));
		repeat (strobeSpacing) @(negedge advanceSignal);

		if (numCases == 0) begin
			$display("No cases were read from the case file");
			otherErrors++;
		end
		if (pendingCount != 0) begin
			$display("%0d frames never produced an output", pendingCount);
			otherErrors++;
		end
		if (caseHits != numCases) begin
			$display("Only %0d of %0d cases were compared with the file", caseHits, numCases);
			otherErrors++;
		end
		$display("Run finished: %0d checker errors, %0d other errors, %0d strobes, %0d outputs",
			errorCount, otherErrors, strobeCount, outputCount);
		if (errorCount == 0 && otherErrors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// Watchdog sized from the case count
	initial begin
		longint limitNs;
		wait (casesLoaded);
		limitNs = longint'(numCases * fftPkg::fftPoints + 20) * strobeSpacing * clockPeriod;
		#(limitNs);
		$display("Timeout: watchdog expired after %0d ns before the test sequence finished",
			limitNs);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/fftPipeline_sva.sv ====
// Stage handshake assertions, bound into every FFT stage
`default_nettype none
`timescale 1ns/1ns

module fftPipelineSva (
	input logic advanceSignal,
	input logic reset,
	input logic inReady,
	input logic outReady,
	input logic stageBusy
);

	// Length of the current busy run
	int busyLength;
	// A frame has been offered since reset
	logic inputSeen;

	always_ff @(posedge advanceSignal) begin
		if (reset) begin
			busyLength <= 0;
			inputSeen <= 1'b0;
		end else begin
			busyLength <= stageBusy ? busyLength + 1 : 0;
			if (inReady) inputSeen <= 1'b1;
		end
	end

	// A load needs an offered frame and a free output
	noLoadWhileReady: assert property (@(posedge advanceSignal) disable iff (reset)
		$rose(stageBusy) |-> $past(inReady) && !$past(outReady))
		else $error("Stage loaded a frame without inReady or while its outReady was high");

	busyRunLength: assert property (@(posedge advanceSignal) disable iff (reset)
		(!stageBusy && busyLength != 0) |-> busyLength == fftPkg::bflyPerStage)
		else $error("stageBusy run was not bflyPerStage cycles long");

	noReadyBeforeInput: assert property (@(posedge advanceSignal) disable iff (reset)
		!inputSeen |-> !outReady)
		else $error("outReady rose before any inReady after reset");

endmodule

bind fftStage fftPipelineSva stageSva_i (
	.advanceSignal(advanceSignal),
	.reset(reset),
	.inReady(inReady),
	.outReady(outReady),
	.stageBusy(stageBusy)
);

`default_nettype wire
